// File: verilog/icb_fanout_defs.svh
// Widths, port count and outstanding depth of the ICB fan-out.
// Region map of the eight target ports.
`ifndef ICB_FANOUT_DEFS_SVH
`define ICB_FANOUT_DEFS_SVH

`define ICB_AW 32
`define ICB_DW 32

`define ICB_PORTS 8           // Real target ports, default target not counted.
`define ICB_OUTS_DEPTH 2      // Max commands in flight.

// Address bits below this one are ignored by the decode.
`define ICB_REGION_LSB 12

// Port n owns the 4 KB region at (n+1) * 0x1000.
`define ICB_BASE_0 32'h0000_1000
`define ICB_BASE_1 32'h0000_2000
`define ICB_BASE_2 32'h0000_3000
`define ICB_BASE_3 32'h0000_4000
`define ICB_BASE_4 32'h0000_5000
`define ICB_BASE_5 32'h0000_6000
`define ICB_BASE_6 32'h0000_7000
`define ICB_BASE_7 32'h0000_8000

`endif

// File: verilog/icb_fanout_pkg.sv
// ICB command and response payload structs.
// Transfer size enum and one-hot target select type.
`default_nettype none

`include "icb_fanout_defs.svh"

package icb_fanout_pkg;

  typedef enum logic [1:0] {
    ICB_SIZE_BYTE = 2'd0,
    ICB_SIZE_HALF = 2'd1,
    ICB_SIZE_WORD = 2'd2
  } icb_size_e;

  // Command payload, valid and ready travel beside it.
  typedef struct packed {
    logic [`ICB_AW-1:0]   addr;
    logic                 read;     // Set for a read, clear for a write.
    logic [`ICB_DW-1:0]   wdata;
    logic [`ICB_DW/8-1:0] wmask;    // One bit per write byte lane.
    icb_size_e            size;
  } icb_cmd_t;

  typedef struct packed {
    logic               err;
    logic [`ICB_DW-1:0] rdata;
  } icb_rsp_t;

  // Bit ICB_PORTS selects the default target.
  typedef logic [`ICB_PORTS:0] port_sel_t;

endpackage

`default_nettype wire

// File: verilog/icb_cmd_buffer.sv
// Two-entry ICB command FIFO.
// Input ready comes from a registered not-full flag.
`default_nettype none

module icb_cmd_buffer (
  input  wire                      clk,
  input  wire                      i_rst_n,
  input  wire                      i_cmd_valid,
  output logic                     o_cmd_ready,
  input  wire icb_fanout_pkg::icb_cmd_t i_cmd,
  output logic                     o_cmd_valid,
  input  wire                      i_cmd_ready,
  output icb_fanout_pkg::icb_cmd_t o_cmd
);

  icb_fanout_pkg::icb_cmd_t mem [2];

  logic [1:0] cnt;
  logic [1:0] cnt_nxt;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       not_full_q;
  logic       push;
  logic       pop;

  assign push    = i_cmd_valid & not_full_q;
  assign pop     = o_cmd_valid & i_cmd_ready;
  assign cnt_nxt = cnt + {1'b0, push} - {1'b0, pop};

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cnt        <= 2'd0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
      not_full_q <= 1'b0;                  // Held low through reset.
    end else begin
      cnt        <= cnt_nxt;
      not_full_q <= (cnt_nxt != 2'd2);
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_cmd;
    end
  end

  assign o_cmd_ready = not_full_q;         // No path back from the output side.
  assign o_cmd_valid = (cnt != 2'd0);
  assign o_cmd       = mem[rd_ptr];

  a_cnt_max: assert property (@(posedge clk) disable iff (!i_rst_n)
    cnt <= 2'd2)
    else $error("Command buffer holds more than two entries.");

endmodule

`default_nettype wire

// File: verilog/icb_addr_decode.sv
// Address decode of the ICB fan-out.
// Region match per port, gated by the port enables, one-hot select out.
`default_nettype none

`include "icb_fanout_defs.svh"

module icb_addr_decode (
  input  wire [`ICB_AW-1:0]          i_addr,
  input  wire [`ICB_PORTS-1:0]       i_port_en,
  output icb_fanout_pkg::port_sel_t  o_sel
);

  localparam int AW  = `ICB_AW;
  localparam int LSB = `ICB_REGION_LSB;

  localparam logic [AW-1:0] BASE [`ICB_PORTS] = '{
    `ICB_BASE_0, `ICB_BASE_1, `ICB_BASE_2, `ICB_BASE_3,
    `ICB_BASE_4, `ICB_BASE_5, `ICB_BASE_6, `ICB_BASE_7
  };

  logic [`ICB_PORTS-1:0] hit;

  genvar g;
  generate
    for (g = 0; g < `ICB_PORTS; g++) begin : g_region
      assign hit[g] = i_port_en[g] & (i_addr[AW-1:LSB] == BASE[g][AW-1:LSB]);
    end
  endgenerate

  assign o_sel = {~(|hit), hit};           // Unmatched goes to the error target.

  // Overlapping regions in the map would show up here.
  always_comb begin
    if (!$isunknown({i_addr, i_port_en})) begin
      a_sel_onehot: assert ($onehot(o_sel))
        else $error("Target select is not one-hot.");
    end
  end

endmodule

`default_nettype wire

// File: verilog/icb_splitter.sv
// ICB command splitter with in-order response return.
// Counts outstanding commands and remembers their target.
// New commands go only to the pending target, up to the depth limit.
`default_nettype none

`include "icb_fanout_defs.svh"

module icb_splitter (
  input  wire                         clk,
  input  wire                         i_rst_n,

  input  wire                         i_cmd_valid,
  output logic                        o_cmd_ready,
  input  wire icb_fanout_pkg::icb_cmd_t  i_cmd,
  input  wire icb_fanout_pkg::port_sel_t i_sel,

  output logic                        o_rsp_valid,
  input  wire                         i_rsp_ready,
  output icb_fanout_pkg::icb_rsp_t    o_rsp,

  output icb_fanout_pkg::port_sel_t   o_tgt_cmd_valid,
  input  wire icb_fanout_pkg::port_sel_t i_tgt_cmd_ready,
  output icb_fanout_pkg::icb_cmd_t [`ICB_PORTS:0] o_tgt_cmd,

  input  wire icb_fanout_pkg::port_sel_t i_tgt_rsp_valid,
  output icb_fanout_pkg::port_sel_t   o_tgt_rsp_ready,
  input  wire icb_fanout_pkg::icb_rsp_t [`ICB_PORTS:0] i_tgt_rsp
);

  localparam int N     = `ICB_PORTS + 1;
  localparam int CNT_W = $clog2(`ICB_OUTS_DEPTH + 1);
  localparam logic [CNT_W-1:0] OUTS_MAX = CNT_W'(`ICB_OUTS_DEPTH);

  logic [CNT_W-1:0]          outs_cnt;
  logic [CNT_W-1:0]          cnt_nxt;
  icb_fanout_pkg::port_sel_t pend_sel;
  icb_fanout_pkg::port_sel_t rsp_sel;
  logic                      none_pend;
  logic                      can_issue;
  logic                      cmd_fire;
  logic                      rsp_fire;

  assign none_pend = (outs_cnt == '0);

  // Same target only, so responses cannot overtake each other.
  assign can_issue = (outs_cnt < OUTS_MAX) & (none_pend | (i_sel == pend_sel));

  assign o_tgt_cmd_valid = i_sel & {N{i_cmd_valid & can_issue}};
  assign o_cmd_ready     = can_issue & (|(i_sel & i_tgt_cmd_ready));
  assign cmd_fire        = i_cmd_valid & o_cmd_ready;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      o_tgt_cmd[i] = o_tgt_cmd_valid[i] ? i_cmd : '0;   // Idle ports see zeros.
    end
  end

  // With nothing pending only a same-cycle answer to the new command is possible.
  assign rsp_sel = none_pend ? i_sel : pend_sel;

  assign o_tgt_rsp_ready = rsp_sel & {N{i_rsp_ready}};
  assign o_rsp_valid     = |(i_tgt_rsp_valid & rsp_sel);
  assign rsp_fire        = o_rsp_valid & i_rsp_ready;

  always_comb begin
    o_rsp = '0;
    for (int i = 0; i < N; i++) begin
      if (rsp_sel[i]) begin
        o_rsp = o_rsp | i_tgt_rsp[i];
      end
    end
  end

  assign cnt_nxt = outs_cnt + CNT_W'(cmd_fire) - CNT_W'(rsp_fire);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      outs_cnt <= '0;
      pend_sel <= '0;
    end else begin
      outs_cnt <= cnt_nxt;
      if (cmd_fire) begin
        pend_sel <= i_sel;
      end
    end
  end

  a_rsp_has_cmd: assert property (@(posedge clk) disable iff (!i_rst_n)
    rsp_fire |-> (!none_pend || cmd_fire))
    else $error("Response with no command outstanding.");

  a_outs_max: assert property (@(posedge clk) disable iff (!i_rst_n)
    outs_cnt <= OUTS_MAX)
    else $error("Outstanding count above the limit.");

endmodule

`default_nettype wire

// File: verilog/icb_err_target.sv
// Default ICB target for unmapped or disabled addresses.
// Answers every command with a registered error response.
`default_nettype none

module icb_err_target (
  input  wire                      clk,
  input  wire                      i_rst_n,
  input  wire                      i_cmd_valid,
  output logic                     o_cmd_ready,
  output logic                     o_rsp_valid,
  input  wire                      i_rsp_ready,
  output icb_fanout_pkg::icb_rsp_t o_rsp
);

  logic rsp_full;

  // One slot, so no new command while a response waits.
  assign o_cmd_ready = ~rsp_full;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      rsp_full <= 1'b0;
    end else if (i_cmd_valid && o_cmd_ready) begin
      rsp_full <= 1'b1;
    end else if (rsp_full && i_rsp_ready) begin
      rsp_full <= 1'b0;
    end
  end

  assign o_rsp_valid = rsp_full;
  assign o_rsp.err   = rsp_full;
  assign o_rsp.rdata = '0;                 // Read data is always zero.

endmodule

`default_nettype wire

// File: verilog/icb_fanout.sv
// ICB one-to-eight fan-out top level.
// Command buffer, address decode, splitter and default error target.
`default_nettype none

`include "icb_fanout_defs.svh"

module icb_fanout (
  input  wire                             clk,
  input  wire                             i_rst_n,
  input  wire [`ICB_PORTS-1:0]            i_port_en,

  input  wire                             i_cmd_valid,
  output logic                            o_cmd_ready,
  input  wire icb_fanout_pkg::icb_cmd_t   i_cmd,

  output logic                            o_rsp_valid,
  input  wire                             i_rsp_ready,
  output icb_fanout_pkg::icb_rsp_t        o_rsp,

  output logic [`ICB_PORTS-1:0]           o_port_cmd_valid,
  input  wire  [`ICB_PORTS-1:0]           i_port_cmd_ready,
  output icb_fanout_pkg::icb_cmd_t [`ICB_PORTS-1:0] o_port_cmd,

  input  wire  [`ICB_PORTS-1:0]           i_port_rsp_valid,
  output logic [`ICB_PORTS-1:0]           o_port_rsp_ready,
  input  wire icb_fanout_pkg::icb_rsp_t [`ICB_PORTS-1:0] i_port_rsp
);

  localparam int DEF = `ICB_PORTS;         // Slice index of the error target.

  logic                                   buf_valid;
  logic                                   buf_ready;
  icb_fanout_pkg::icb_cmd_t               buf_cmd;
  icb_fanout_pkg::port_sel_t              sel;

  icb_fanout_pkg::port_sel_t              tgt_cmd_valid;
  icb_fanout_pkg::port_sel_t              tgt_cmd_ready;
  icb_fanout_pkg::icb_cmd_t [`ICB_PORTS:0] tgt_cmd;
  icb_fanout_pkg::port_sel_t              tgt_rsp_valid;
  icb_fanout_pkg::port_sel_t              tgt_rsp_ready;
  icb_fanout_pkg::icb_rsp_t [`ICB_PORTS:0] tgt_rsp;

  logic                                   err_cmd_ready;
  logic                                   err_rsp_valid;
  icb_fanout_pkg::icb_rsp_t               err_rsp;

  icb_cmd_buffer u_cmd_buffer (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .o_cmd_ready (o_cmd_ready),
    .i_cmd       (i_cmd),
    .o_cmd_valid (buf_valid),
    .i_cmd_ready (buf_ready),
    .o_cmd       (buf_cmd)
  );

  icb_addr_decode u_addr_decode (
    .i_addr    (buf_cmd.addr),
    .i_port_en (i_port_en),
    .o_sel     (sel)
  );

  icb_splitter u_splitter (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_cmd_valid     (buf_valid),
    .o_cmd_ready     (buf_ready),
    .i_cmd           (buf_cmd),
    .i_sel           (sel),
    .o_rsp_valid     (o_rsp_valid),
    .i_rsp_ready     (i_rsp_ready),
    .o_rsp           (o_rsp),
    .o_tgt_cmd_valid (tgt_cmd_valid),
    .i_tgt_cmd_ready (tgt_cmd_ready),
    .o_tgt_cmd       (tgt_cmd),
    .i_tgt_rsp_valid (tgt_rsp_valid),
    .o_tgt_rsp_ready (tgt_rsp_ready),
    .i_tgt_rsp       (tgt_rsp)
  );

  // The error target ignores the payload of its slice.
  icb_err_target u_err_target (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (tgt_cmd_valid[DEF]),
    .o_cmd_ready (err_cmd_ready),
    .o_rsp_valid (err_rsp_valid),
    .i_rsp_ready (tgt_rsp_ready[DEF]),
    .o_rsp       (err_rsp)
  );

  assign o_port_cmd_valid = tgt_cmd_valid[`ICB_PORTS-1:0];
  assign o_port_cmd       = tgt_cmd[`ICB_PORTS-1:0];
  assign tgt_cmd_ready    = {err_cmd_ready, i_port_cmd_ready};

  assign tgt_rsp_valid    = {err_rsp_valid, i_port_rsp_valid};
  assign tgt_rsp          = {err_rsp, i_port_rsp};
  assign o_port_rsp_ready = tgt_rsp_ready[`ICB_PORTS-1:0];

endmodule

`default_nettype wire

// File: sim/tb_icb_fanout.sv
// Testbench of the ICB fan-out.
// Random initiator, eight target models, reference functions,
// an in-order response checker and a cycle limit.
`default_nettype none

`include "icb_fanout_defs.svh"

module tb_icb_fanout;

  localparam int NUM_CMDS       = 400;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 30;
  localparam int NP             = `ICB_PORTS;
  localparam int LSB            = `ICB_REGION_LSB;
  localparam int RB             = `ICB_AW - `ICB_REGION_LSB;
  localparam int MW             = `ICB_DW / 8;
  localparam logic [NP-1:0] PORT_EN = 8'b1101_1011;   // Ports 2 and 5 switched off.

  typedef struct packed {
    icb_fanout_pkg::icb_rsp_t rsp;
    int                       due;                     // First cycle the answer may show.
  } tgt_item_t;

  typedef struct packed {
    icb_fanout_pkg::icb_rsp_t rsp;
    int                       port;
  } exp_item_t;

  logic                              clk;
  logic                              i_rst_n;
  logic [NP-1:0]                     i_port_en;
  logic                              i_cmd_valid;
  logic                              o_cmd_ready;
  icb_fanout_pkg::icb_cmd_t          i_cmd;
  logic                              o_rsp_valid;
  logic                              i_rsp_ready;
  icb_fanout_pkg::icb_rsp_t          o_rsp;
  logic [NP-1:0]                     o_port_cmd_valid;
  logic [NP-1:0]                     i_port_cmd_ready;
  icb_fanout_pkg::icb_cmd_t [NP-1:0] o_port_cmd;
  logic [NP-1:0]                     i_port_rsp_valid;
  logic [NP-1:0]                     o_port_rsp_ready;
  icb_fanout_pkg::icb_rsp_t [NP-1:0] i_port_rsp;

  integer                   seed = 11447;
  int                       cyc = 0;
  int                       created = 0;
  int                       issued = 0;
  int                       last_port = 0;
  logic                     cmd_pending = 1'b0;
  icb_fanout_pkg::icb_cmd_t cur_cmd;
  icb_fanout_pkg::icb_cmd_t in_q [$];                 // Accepted, not yet seen on a port.
  exp_item_t                exp_q [$];                // Expected responses in issue order.
  icb_fanout_pkg::icb_rsp_t got_q [$];
  tgt_item_t                tgt_q [NP][$];

  icb_fanout uut (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_port_en        (i_port_en),
    .i_cmd_valid      (i_cmd_valid),
    .o_cmd_ready      (o_cmd_ready),
    .i_cmd            (i_cmd),
    .o_rsp_valid      (o_rsp_valid),
    .i_rsp_ready      (i_rsp_ready),
    .o_rsp            (o_rsp),
    .o_port_cmd_valid (o_port_cmd_valid),
    .i_port_cmd_ready (i_port_cmd_ready),
    .o_port_cmd       (o_port_cmd),
    .i_port_rsp_valid (i_port_rsp_valid),
    .o_port_rsp_ready (o_port_rsp_ready),
    .i_port_rsp       (i_port_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic report_mismatch(input string name, input string want, input string got);
    $display("[ERROR] time %0t %s expected %s got %s", $time, name, want, got);
    abort_run("Value mismatch.");
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      abort_run("Timeout, the run did not finish within the cycle limit.");
    end
  end

  function automatic int pick(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // Port n owns region (n+1), and only while it is enabled.
  function automatic int ref_port(input logic [`ICB_AW-1:0] addr, input logic [NP-1:0] en);
    int p;
    p = NP;
    for (int i = 0; i < NP; i++) begin
      if (en[i] && addr[`ICB_AW-1:LSB] == RB'(i + 1)) begin
        p = i;
      end
    end
    return p;
  endfunction

  function automatic logic [`ICB_DW-1:0] ref_rdata(input int port,
                                                   input logic [`ICB_AW-1:0] addr);
    return addr ^ (32'h5A5A_0000 + 32'(port) * 32'h0000_1111);
  endfunction

  function automatic icb_fanout_pkg::icb_rsp_t ref_rsp(input icb_fanout_pkg::icb_cmd_t c);
    icb_fanout_pkg::icb_rsp_t r;
    int                       p;
    p = ref_port(c.addr, PORT_EN);
    r.err   = (p == NP);
    r.rdata = (p == NP) ? '0 : ref_rdata(p, c.addr);   // Default target reads zero.
    return r;
  endfunction

  task automatic build_cmd(output icb_fanout_pkg::icb_cmd_t c);
    int port;
    port = (pick(2) == 0) ? last_port : pick(NP);
    if (pick(10) < 8) begin
      c.addr    = {RB'(port + 1), LSB'(pick(1 << LSB))};
      last_port = port;
    end else begin
      c.addr = {RB'((pick(2) == 0) ? 0 : NP + 1 + pick(64)), LSB'(pick(1 << LSB))};
    end
    c.read  = 1'(pick(2));
    c.wdata = $random(seed);
    c.wmask = MW'(pick(16));
    c.size  = icb_fanout_pkg::icb_size_e'(2'(pick(3)));
  endtask

  task automatic drive_cycle();
    if (!cmd_pending && created < NUM_CMDS && pick(4) != 0) begin
      build_cmd(cur_cmd);
      cmd_pending = 1'b1;
      created++;
    end
    i_cmd_valid = cmd_pending;                          // Held until accepted.
    i_cmd       = cmd_pending ? cur_cmd : '0;
    i_rsp_ready = (pick(4) != 0);
    for (int p = 0; p < NP; p++) begin
      i_port_cmd_ready[p] = (pick(3) != 0);
      if (tgt_q[p].size() > 0 && cyc >= tgt_q[p][0].due) begin
        i_port_rsp_valid[p] = 1'b1;
        i_port_rsp[p]       = tgt_q[p][0].rsp;
      end else begin
        i_port_rsp_valid[p] = 1'b0;
        i_port_rsp[p]       = '0;
      end
    end
  endtask

  task automatic sample_cycle();
    exp_item_t e;
    tgt_item_t t;
    int        older;
    if (o_rsp_valid && i_rsp_ready) begin
      got_q.push_back(o_rsp);
    end
    assert ($countones(o_port_cmd_valid) <= 1)
      else abort_run("More than one port shows a valid command.");
    for (int p = 0; p < NP; p++) begin
      if (i_port_rsp_valid[p] && o_port_rsp_ready[p]) begin
        assert (o_rsp_valid && i_rsp_ready)
          else abort_run("A port response was taken but not passed to the initiator.");
        tgt_q[p].delete(0);
      end
      if (!o_port_cmd_valid[p]) begin
        assert (o_port_cmd[p] == '0)
          else report_mismatch($sformatf("o_port_cmd[%0d]", p), "0",
                               $sformatf("%h", o_port_cmd[p]));
      end else begin
        // Commands for the error target leave the buffer unseen.
        while (in_q.size() > 0 && ref_port(in_q[0].addr, PORT_EN) == NP) begin
          in_q.delete(0);
        end
        assert (in_q.size() > 0)
          else abort_run("A port shows a command that was never issued.");
        assert (ref_port(in_q[0].addr, PORT_EN) == p)
          else report_mismatch("o_port_cmd_valid port",
                               $sformatf("%0d", ref_port(in_q[0].addr, PORT_EN)),
                               $sformatf("%0d", p));
        assert (o_port_cmd[p] == in_q[0])
          else report_mismatch($sformatf("o_port_cmd[%0d]", p),
                               $sformatf("%h", in_q[0]), $sformatf("%h", o_port_cmd[p]));
        if (i_port_cmd_ready[p]) begin
          older = exp_q.size() - in_q.size();          // Issued ahead and still unanswered.
          assert (older < `ICB_OUTS_DEPTH)
            else abort_run("More port commands in flight than the outstanding limit.");
          for (int i = 0; i < older; i++) begin
            assert (exp_q[i].port == p)
              else abort_run("Command went to a new target while responses were pending.");
          end
          t.rsp.err   = 1'b0;
          t.rsp.rdata = ref_rdata(p, o_port_cmd[p].addr);
          t.due       = cyc + 1 + pick(6);
          tgt_q[p].push_back(t);
          in_q.delete(0);
        end
      end
    end
    if (i_cmd_valid && o_cmd_ready) begin
      e.rsp  = ref_rsp(i_cmd);
      e.port = ref_port(i_cmd.addr, PORT_EN);
      exp_q.push_back(e);
      in_q.push_back(i_cmd);
      cmd_pending = 1'b0;
      issued++;
    end
  endtask

  // Responses seen in the last cycle, checked in issue order.
  always @(posedge clk) begin : rsp_compare
    icb_fanout_pkg::icb_rsp_t got;
    exp_item_t                want;
    while (got_q.size() > 0) begin
      got = got_q.pop_front();
      assert (exp_q.size() > 0)
        else abort_run("A response arrived with no command outstanding.");
      want = exp_q.pop_front();
      assert (got == want.rsp)
        else report_mismatch("o_rsp", $sformatf("%h", want.rsp), $sformatf("%h", got));
    end
  end

  initial begin : main
    int leftover;
    i_rst_n          = 1'b0;
    i_port_en        = PORT_EN;
    i_cmd_valid      = 1'b0;
    i_cmd            = '0;
    i_rsp_ready      = 1'b0;
    i_port_cmd_ready = '0;
    i_port_rsp_valid = '0;
    i_port_rsp       = '0;
    leftover         = 0;
    repeat (10) @(posedge clk);
    #1;
    assert (o_cmd_ready == 1'b0)
      else report_mismatch("o_cmd_ready", "0", $sformatf("%b", o_cmd_ready));
    @(negedge clk);
    i_rst_n = 1'b1;
    #1;
    assert (o_port_cmd_valid == '0)
      else report_mismatch("o_port_cmd_valid", "0", $sformatf("%b", o_port_cmd_valid));
    assert (o_rsp_valid == 1'b0)
      else report_mismatch("o_rsp_valid", "0", $sformatf("%b", o_rsp_valid));
    while (issued < NUM_CMDS || exp_q.size() > 0) begin
      @(negedge clk);
      drive_cycle();
      #1;
      sample_cycle();
    end
    leftover = got_q.size();
    for (int p = 0; p < NP; p++) begin
      leftover += tgt_q[p].size();
    end
    if (leftover == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("Target responses were left over at the end of the run.");
    end
  end

endmodule

`default_nettype wire

// File: icb_fanout.f
+incdir+verilog
verilog/icb_fanout_pkg.sv
verilog/icb_cmd_buffer.sv
verilog/icb_addr_decode.sv
verilog/icb_splitter.sv
verilog/icb_err_target.sv
verilog/icb_fanout.sv
sim/tb_icb_fanout.sv

// File: Makefile
# Verilator build and run of the ICB fan-out testbench.
# Any variable below can be overridden on the command line.

TOP       ?= tb_icb_fanout
FILELIST  ?= icb_fanout.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= \*\* PASS \*\*

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := verilog/icb_fanout_defs.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) && echo "Simulation passed." || \
	  (echo "Simulation failed, see $(LOG)."; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
